/* files.f */
logic/core_pkg.sv
logic/src_buf.sv
logic/exec_seq.sv
logic/reduce_alu.sv
logic/core_top.sv
test/core_tb.sv

/* logic/core_pkg.sv */
package core_pkg;

    // one source word, also the result width
    parameter int data_w = 32;

    // reduction opcodes
    typedef enum logic [1:0] {
        op_sum = 2'd0, // wraps modulo 2^32
        op_max = 2'd1, // unsigned
        op_min = 2'd2, // unsigned
        op_xor = 2'd3
    } op_e;

    // sequencer states
    typedef enum logic [1:0] {
        seq_idle  = 2'd0,
        seq_issue = 2'd1, // one read per cycle
        seq_drain = 2'd2  // last word still returning
    } seq_state_e;

endpackage

/* logic/core_top.sv */
`timescale 1ns/1ps

module core_top #(
    parameter int row_w = 9
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         load_v,
    input  logic [row_w-1:0]             load_row,
    input  logic [63:0]                  load_data,
    input  logic                         start,
    input  core_pkg::op_e                start_op,
    input  logic [row_w:0]               start_len_m1,
    output logic                         busy,
    output logic                         result_v,
    output logic [core_pkg::data_w-1:0]  result
);
    import core_pkg::*;

    logic              wr_bank;
    logic              rd_v;
    logic [row_w+1:0]  rd_addr;
    logic [data_w-1:0] rd_data;
    logic              op_v;
    op_e               op;
    logic              word_v;
    logic              word_last;

    // double-buffered source memory
    src_buf #(
        .row_w (row_w)
    ) u_src_buf (
        .clk       (clk),
        .load_v    (load_v),
        .load_row  (load_row),
        .load_data (load_data),
        .wr_bank   (wr_bank),
        .rd_v      (rd_v),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    exec_seq #(
        .row_w (row_w)
    ) u_exec_seq (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .start_op     (start_op),
        .start_len_m1 (start_len_m1),
        .wr_bank      (wr_bank),
        .rd_v         (rd_v),
        .rd_addr      (rd_addr),
        .op_v         (op_v),
        .op           (op),
        .word_v       (word_v),
        .word_last    (word_last),
        .busy         (busy)
    );

    // rd_data is qualified by word_v
    reduce_alu u_reduce_alu (
        .clk       (clk),
        .rst       (rst),
        .op_v      (op_v),
        .op        (op),
        .word_v    (word_v),
        .word_last (word_last),
        .word      (rd_data),
        .result_v  (result_v),
        .result    (result)
    );

endmodule

/* logic/exec_seq.sv */
`timescale 1ns/1ps

module exec_seq #(
    parameter int row_w = 9
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  core_pkg::op_e    start_op,
    input  logic [row_w:0]   start_len_m1,
    output logic             wr_bank,
    output logic             rd_v,
    output logic [row_w+1:0] rd_addr,
    output logic             op_v,
    output core_pkg::op_e    op,
    output logic             word_v,
    output logic             word_last,
    output logic             busy
);
    import core_pkg::*;

    seq_state_e state;
    seq_state_e state_nxt;

    logic           fill_bank; // host side bank, exec uses the other one
    logic [row_w:0] word_idx;
    logic [row_w:0] len_m1;
    logic           accept;
    logic           issue_last;

    // starts while busy are dropped
    assign accept     = start && (state == seq_idle);
    assign issue_last = (state == seq_issue) && (word_idx == len_m1);

    always_comb begin
        state_nxt = state;
        case (state)
            seq_idle: begin
                if (accept) begin
                    state_nxt = seq_issue;
                end
            end
            seq_issue: begin
                if (word_idx == len_m1) begin
                    state_nxt = seq_drain;
                end
            end
            seq_drain: state_nxt = seq_idle; // final word returns here
            default:   state_nxt = seq_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= seq_idle;
            fill_bank <= 1'b0;
            word_idx  <= '0;
            op_v      <= 1'b0;
            word_v    <= 1'b0;
            word_last <= 1'b0;
        end else begin
            state  <= state_nxt;
            op_v   <= accept;
            word_v <= rd_v;               // matches read latency
            word_last <= issue_last;
            if (accept) begin
                fill_bank <= ~fill_bank;  // swap banks, visible from T+1
                word_idx  <= '0;
            end else if (state == seq_issue) begin
                word_idx <= word_idx + 1'b1;
            end
        end
    end

    // job parameters held for the whole job
    always_ff @(posedge clk) begin
        if (accept) begin
            op     <= start_op;
            len_m1 <= start_len_m1;
        end
    end

    assign wr_bank = fill_bank;
    assign rd_v    = (state == seq_issue);
    assign rd_addr = {~fill_bank, word_idx};
    assign busy    = (state != seq_idle);

endmodule

/* logic/reduce_alu.sv */
`timescale 1ns/1ps

module reduce_alu (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         op_v,
    input  core_pkg::op_e                op,
    input  logic                         word_v,
    input  logic                         word_last,
    input  logic [core_pkg::data_w-1:0]  word,
    output logic                         result_v,
    output logic [core_pkg::data_w-1:0]  result
);
    import core_pkg::*;

    op_e               op_q;
    logic              empty;    // no word taken yet in this job
    logic [data_w-1:0] acc;
    logic [data_w-1:0] combined;

    // next accumulator value
    always_comb begin
        if (empty) begin
            combined = word;
        end else begin
            case (op_q)
                op_sum:  combined = acc + word;
                op_max:  combined = (word > acc) ? word : acc;
                op_min:  combined = (word < acc) ? word : acc;
                default: combined = acc ^ word;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            op_q     <= op_sum;
            empty    <= 1'b1;
            result_v <= 1'b0;
        end else begin
            result_v <= word_v && word_last;
            if (op_v) begin
                op_q  <= op;
                empty <= 1'b1;
            end else if (word_v) begin
                empty <= 1'b0;
            end
        end
    end

    // payload path
    always_ff @(posedge clk) begin
        if (word_v) begin
            acc <= combined;
            if (word_last) begin
                result <= combined; // held until the next job ends
            end
        end
    end

endmodule

/* logic/src_buf.sv */
`timescale 1ns/1ps

module src_buf #(
    parameter int row_w = 9
) (
    input  logic                         clk,
    input  logic                         load_v,
    input  logic [row_w-1:0]             load_row,
    input  logic [63:0]                  load_data,
    input  logic                         wr_bank,
    input  logic                         rd_v,
    input  logic [row_w+1:0]             rd_addr,
    output logic [core_pkg::data_w-1:0]  rd_data
);
    import core_pkg::*;

    localparam int depth = 2 ** row_w;

    // bank 0
    logic [data_w-1:0] bank0_even [0:depth-1];
    logic [data_w-1:0] bank0_odd  [0:depth-1];
    // bank 1
    logic [data_w-1:0] bank1_even [0:depth-1];
    logic [data_w-1:0] bank1_odd  [0:depth-1];

    logic             rd_bank;
    logic [row_w-1:0] rd_row;
    logic             rd_lane;

    // rd_addr is {bank, row, lane}
    assign rd_bank = rd_addr[row_w+1];
    assign rd_row  = rd_addr[row_w:1];
    assign rd_lane = rd_addr[0];

    // low half to even lane, high half to odd lane
    always_ff @(posedge clk) begin
        if (load_v && !wr_bank) begin
            bank0_even[load_row] <= load_data[data_w-1:0];
            bank0_odd[load_row]  <= load_data[2*data_w-1:data_w];
        end
    end

    always_ff @(posedge clk) begin
        if (load_v && wr_bank) begin
            bank1_even[load_row] <= load_data[data_w-1:0];
            bank1_odd[load_row]  <= load_data[2*data_w-1:data_w];
        end
    end

    // registered read, data follows rd_v by one cycle
    always_ff @(posedge clk) begin
        if (rd_v) begin
            case ({rd_bank, rd_lane})
                2'b00:   rd_data <= bank0_even[rd_row];
                2'b01:   rd_data <= bank0_odd[rd_row];
                2'b10:   rd_data <= bank1_even[rd_row];
                default: rd_data <= bank1_odd[rd_row];
            endcase
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the core testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing \
    -f files.f \
    --top-module core_tb \
    --Mdir obj_dir \
    -o core_tb_sim

./obj_dir/core_tb_sim > sim.log 2>&1
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0

/* test/core_tb.sv */
`timescale 1ns/1ps

module core_tb;
    import core_pkg::*;

    localparam int row_w      = 4;
    localparam int rows       = 2 ** row_w;
    localparam int words      = 2 * rows;
    localparam int max_cycles = 20000; // 60 jobs with loads and gaps, plus margin

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  load_v;
    logic [row_w-1:0]      load_row;
    logic [63:0]           load_data;
    logic                  start;
    op_e                   start_op;
    logic [row_w:0]        start_len_m1;
    logic                  busy;
    logic                  result_v;
    logic [data_w-1:0]     result;

    integer seed;
    int     cycle_cnt     = 0;
    int     model_errors  = 0;
    int     drive_errors  = 0;
    int     jobs_accepted = 0;
    int     results_seen  = 0;

    // reference model state
    logic [63:0]       m_bank [0:1][0:rows-1];
    logic              m_fill;
    logic              exp_pending;
    logic              exp_busy;
    int                exp_cycle;
    int                m_len;
    logic [data_w-1:0] exp_result;

    core_top #(
        .row_w (row_w)
    ) u_dut (
        .clk          (clk),
        .rst          (rst),
        .load_v       (load_v),
        .load_row     (load_row),
        .load_data    (load_data),
        .start        (start),
        .start_op     (start_op),
        .start_len_m1 (start_len_m1),
        .busy         (busy),
        .result_v     (result_v),
        .result       (result)
    );

    always #5 clk = ~clk;

    // cycle count and run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("jobs accepted %0d, results %0d, errors %0d",
                     jobs_accepted, results_seen, model_errors + drive_errors);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // word w is half (w mod 2) of row w/2
    function automatic logic [data_w-1:0] ref_reduce(input op_e op, input int len,
                                                     input logic bank);
        logic [data_w-1:0] acc;
        logic [data_w-1:0] w_val;
        logic [63:0]       row;
        logic [row_w-1:0]  ri;
        int                rw;
        acc = '0;
        for (int w = 0; w < len; w++) begin
            rw    = w / 2;
            ri    = rw[row_w-1:0];
            row   = m_bank[bank][ri];
            w_val = (w % 2 == 1) ? row[63:32] : row[31:0];
            if (w == 0) begin
                acc = w_val;
            end else begin
                case (op)
                    op_sum:  acc = acc + w_val;             // wraps at 32 bits
                    op_max:  acc = (w_val > acc) ? w_val : acc;
                    op_min:  acc = (w_val < acc) ? w_val : acc;
                    default: acc = acc ^ w_val;
                endcase
            end
        end
        return acc;
    endfunction

    // model sampled mid-cycle, where inputs and outputs are settled
    always @(negedge clk) begin
        if (rst) begin
            m_fill      = 1'b0;
            exp_pending = 1'b0;
        end else begin
            if (result_v) begin
                if (!exp_pending || cycle_cnt != exp_cycle) begin
                    model_errors++;
                    $display("unexpected result_v at time %0t with no job due to end", $time);
                end else begin
                    results_seen++;
                    exp_pending = 1'b0;
                    if (result !== exp_result) begin
                        model_errors++;
                        $display("error: time %0t signal result got %h expected %h",
                                 $time, result, exp_result);
                    end
                end
            end else if (exp_pending && cycle_cnt == exp_cycle) begin
                model_errors++;
                exp_pending = 1'b0;
                $display("missing result_v at time %0t, job ended without a result", $time);
            end

            exp_busy = exp_pending;   // busy up to the cycle before result_v
            if (busy !== exp_busy) begin
                model_errors++;
                $display("error: time %0t signal busy got %b expected %b",
                         $time, busy, exp_busy);
            end

            if (load_v) begin
                m_bank[m_fill][load_row] = load_data;
            end

            // same rule as the core, a start only counts while idle
            if (start && !busy) begin
                m_fill = ~m_fill;
                m_len  = int'(start_len_m1) + 1;
                exp_result  = ref_reduce(start_op, m_len, ~m_fill);
                exp_cycle   = cycle_cnt + m_len + 2;
                exp_pending = 1'b1;
                jobs_accepted++;
            end
        end
    end

    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic clear_inputs;
        load_v = 1'b0;
        start  = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        clear_inputs();
        repeat (n) next_cycle();
    endtask

    task automatic drive_load(input logic [row_w-1:0] row);
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        load_v    = 1'b1;
        load_row  = row;
        load_data = {hi, lo};
    endtask

    // every row of the current fill bank
    task automatic fill_whole_bank;
        for (int i = 0; i < rows; i++) begin
            drive_load(i[row_w-1:0]);
            next_cycle();
        end
        clear_inputs();
    endtask

    // start a job, keep the host busy meanwhile, return in the result_v cycle
    task automatic run_job(input op_e op, input int len, input int n_loads,
                           input logic poke, input logic load_first);
        int          lm1;
        int          waited;
        int          loads_done;
        logic [31:0] rnd;
        logic        seen;
        lm1          = len - 1;
        load_v       = 1'b0;
        start        = 1'b1;
        start_op     = op;
        start_len_m1 = lm1[row_w:0];
        if (load_first) begin
            rnd = $random(seed);
            drive_load(rnd[row_w-1:0]);  // still goes to the bank about to run
        end
        next_cycle();
        waited     = 0;
        loads_done = 0;
        seen       = 1'b0;
        while (!seen && waited < len + 8) begin
            clear_inputs();
            if (loads_done < n_loads) begin
                rnd = $random(seed);
                drive_load(rnd[row_w-1:0]);
                loads_done++;
            end
            if (poke && waited == 1) begin
                rnd          = $random(seed);
                start        = 1'b1;     // core is busy here
                start_op     = op_e'(rnd[1:0]);
                start_len_m1 = rnd[row_w+2:2];
            end
            next_cycle();
            waited++;
            seen = result_v;
        end
        clear_inputs();
        if (!seen) begin
            drive_errors++;
            $display("no result_v within %0d cycles of a start, time %0t", len + 8, $time);
        end
    endtask

    initial begin
        logic [31:0] rnd;
        op_e         op;
        int          len;
        int          n_loads;
        int          gap;
        seed         = 32'hc292_a331;
        rst          = 1'b1;
        load_v       = 1'b0;
        load_row     = '0;
        load_data    = '0;
        start        = 1'b0;
        start_op     = op_sum;
        start_len_m1 = '0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        idle_cycles(2);

        // each opcode over a full bank, both banks end up loaded
        fill_whole_bank();
        run_job(op_sum, words, 0, 1'b0, 1'b0);
        fill_whole_bank();
        run_job(op_max, words, 0, 1'b0, 1'b0);
        fill_whole_bank();
        run_job(op_min, words, 0, 1'b0, 1'b0);
        fill_whole_bank();
        run_job(op_xor, words, 0, 1'b0, 1'b0);

        // short and odd lengths for lane order
        idle_cycles(2);
        run_job(op_sum, 1, 0, 1'b0, 1'b0);
        run_job(op_xor, 2, 0, 1'b0, 1'b0);
        run_job(op_max, 7, 0, 1'b0, 1'b0);
        run_job(op_min, words, 0, 1'b0, 1'b0);

        // loads during a job, then reduce what was loaded
        run_job(op_sum, words, rows, 1'b0, 1'b0);
        run_job(op_xor, words, 0, 1'b0, 1'b0);

        // extra starts while busy
        run_job(op_max, 10, 0, 1'b1, 1'b0);
        run_job(op_sum, 9, 0, 1'b1, 1'b1);

        for (int j = 0; j < 48; j++) begin
            rnd     = $random(seed);
            op      = op_e'(rnd[1:0]);
            len     = (rnd[3:2] == 2'd0) ? words : int'(rnd[8:4]) + 1;
            n_loads = int'(rnd[12:9]);
            gap     = int'(rnd[18:17]);  // zero starts in the result_v cycle
            idle_cycles(gap);
            run_job(op, len, n_loads, rnd[14], rnd[15] & rnd[16]);
        end

        idle_cycles(4);
        if (exp_pending) begin
            drive_errors++;
            $display("a result was still expected when the run ended");
        end
        $display("jobs accepted %0d, results %0d, errors %0d",
                 jobs_accepted, results_seen, model_errors + drive_errors);
        if (model_errors + drive_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
